/* Bender.yml */
package:
  name: fdtd_mem_ctrl

sources:
  - include_dirs:
      - common
    files:
      - common/fdtd_pkg.sv
      - source/mem_word_port.sv
      - source/irq_ctrl.sv
      - sweep/field_addr_gen.sv
      - sweep/sweep_fsm.sv
      - source/fdtd_mem_ctrl.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_mem_model.sv
      - tests/tb_fdtd_mem_ctrl.sv

/* common/fdtd_params.svh */
`ifndef FDTD_PARAMS_SVH
`define FDTD_PARAMS_SVH

// byte address width of both memory ports
`define FDTD_ADDR_W 32

// one field value per word
`define FDTD_DATA_W 32

// sweep length in words
`define FDTD_SIZE_W 16

// words per block, and the index width that covers them
`define FDTD_BLOCK_WORDS 8
`define FDTD_BLK_IDX_W 3

`endif

/* common/fdtd_pkg.sv */
`default_nettype none

package fdtd_pkg;

    `include "fdtd_params.svh"

    typedef enum logic {
        FIELD_HY = 1'b0,
        FIELD_EZ = 1'b1
    } field_e;

    // memory port payloads
    typedef struct packed {
        logic [`FDTD_ADDR_W-1:0] addr;
    } mem_rd_cmd_t;

    typedef struct packed {
        logic [`FDTD_ADDR_W-1:0] addr;
        logic [`FDTD_DATA_W-1:0] data;
    } mem_wr_cmd_t;

    typedef struct packed {
        logic [`FDTD_DATA_W-1:0] data;
    } mem_rd_rsp_t;

    // sweep configuration, sampled on start
    typedef struct packed {
        logic [`FDTD_ADDR_W-1:0] hy_base;
        logic [`FDTD_ADDR_W-1:0] ez_base;
        logic [`FDTD_SIZE_W-1:0] size;
        field_e                  field;
    } sweep_cfg_t;

    // calc unit side
    typedef struct packed {
        logic                       valid;
        field_e                     field;
        logic [`FDTD_BLK_IDX_W-1:0] idx;
        logic [`FDTD_DATA_W-1:0]    data;
    } field_beat_t;

    typedef struct packed {
        logic                    valid;
        logic [`FDTD_DATA_W-1:0] data;
    } upd_beat_t;

endpackage

`default_nettype wire

/* sim.f */
+incdir+common
common/fdtd_pkg.sv
source/mem_word_port.sv
source/irq_ctrl.sv
sweep/field_addr_gen.sv
sweep/sweep_fsm.sv
source/fdtd_mem_ctrl.sv
tests/tb_mem_model.sv
tests/tb_fdtd_mem_ctrl.sv

/* source/fdtd_mem_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fdtd_params.svh"

module fdtd_mem_ctrl
(
    input  logic                  ACLK,
    input  logic                  ARESETn,

    input  logic                  start_i,
    input  fdtd_pkg::sweep_cfg_t  cfg_i,
    output logic                  busy_o,

    input  logic                  irq_en_i,
    input  logic                  irq_clr_i,
    output logic                  irq_pending_o,
    output logic                  irq_o,

    output fdtd_pkg::field_beat_t rd_beat_o,
    output logic                  calc_start_o,
    input  fdtd_pkg::upd_beat_t   upd_beat_i,
    output logic                  upd_ready_o,

    output logic                  mem_rd_req_o,
    output fdtd_pkg::mem_rd_cmd_t mem_rd_cmd_o,
    input  logic                  mem_rd_ack_i,
    input  fdtd_pkg::mem_rd_rsp_t mem_rd_rsp_i,

    output logic                  mem_wr_req_o,
    output fdtd_pkg::mem_wr_cmd_t mem_wr_cmd_o,
    input  logic                  mem_wr_ack_i
);
    import fdtd_pkg::*;

    logic                   addr_load;
    field_e                 field;
    logic [`FDTD_SIZE_W-1:0] word_idx;
    logic [`FDTD_ADDR_W-1:0] addr;

    logic                   rd_go;
    logic                   rd_done;
    mem_rd_cmd_t            rd_cmd;
    mem_rd_rsp_t            rd_rsp;

    logic                   wr_go;
    logic                   wr_done;
    mem_wr_cmd_t            wr_cmd;

    // bases only reload on a start the FSM accepts
    assign addr_load = start_i & ~busy_o;

    sweep_fsm u_sweep_fsm
    (
        .ACLK         ( ACLK         ),
        .ARESETn      ( ARESETn      ),
        .start_i      ( start_i      ),
        .cfg_i        ( cfg_i        ),
        .addr_i       ( addr         ),
        .field_o      ( field        ),
        .word_idx_o   ( word_idx     ),
        .rd_go_o      ( rd_go        ),
        .rd_cmd_o     ( rd_cmd       ),
        .rd_done_i    ( rd_done      ),
        .rd_rsp_i     ( rd_rsp       ),
        .wr_go_o      ( wr_go        ),
        .wr_cmd_o     ( wr_cmd       ),
        .wr_done_i    ( wr_done      ),
        .rd_beat_o    ( rd_beat_o    ),
        .calc_start_o ( calc_start_o ),
        .upd_beat_i   ( upd_beat_i   ),
        .upd_ready_o  ( upd_ready_o  ),
        .busy_o       ( busy_o       )
    );

    field_addr_gen u_field_addr_gen
    (
        .ACLK       ( ACLK      ),
        .ARESETn    ( ARESETn   ),
        .load_i     ( addr_load ),
        .cfg_i      ( cfg_i     ),
        .field_i    ( field     ),
        .word_idx_i ( word_idx  ),
        .addr_o     ( addr      )
    );

    mem_word_port #(
        .cmd_t ( mem_rd_cmd_t ),
        .rsp_t ( mem_rd_rsp_t )
    ) u_rd_port (
        .ACLK    ( ACLK         ),
        .ARESETn ( ARESETn      ),
        .go_i    ( rd_go        ),
        .cmd_i   ( rd_cmd       ),
        .done_o  ( rd_done      ),
        .rsp_o   ( rd_rsp       ),
        .req_o   ( mem_rd_req_o ),
        .cmd_o   ( mem_rd_cmd_o ),
        .ack_i   ( mem_rd_ack_i ),
        .rsp_i   ( mem_rd_rsp_i )
    );

    // writes return nothing but the ack
    mem_word_port #(
        .cmd_t ( mem_wr_cmd_t ),
        .rsp_t ( logic        )
    ) u_wr_port (
        .ACLK    ( ACLK         ),
        .ARESETn ( ARESETn      ),
        .go_i    ( wr_go        ),
        .cmd_i   ( wr_cmd       ),
        .done_o  ( wr_done      ),
        .rsp_o   (              ),
        .req_o   ( mem_wr_req_o ),
        .cmd_o   ( mem_wr_cmd_o ),
        .ack_i   ( mem_wr_ack_i ),
        .rsp_i   ( 1'b0         )
    );

    irq_ctrl u_irq_ctrl
    (
        .ACLK      ( ACLK          ),
        .ARESETn   ( ARESETn       ),
        .busy_i    ( busy_o        ),
        .en_i      ( irq_en_i      ),
        .clr_i     ( irq_clr_i     ),
        .pending_o ( irq_pending_o ),
        .irq_o     ( irq_o         )
    );

endmodule

`default_nettype wire

/* source/irq_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module irq_ctrl
(
    input  logic ACLK,
    input  logic ARESETn,

    input  logic busy_i,
    input  logic en_i,
    input  logic clr_i,
    output logic pending_o,
    output logic irq_o
);
    logic busy_q;
    logic pending_q;

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            busy_q    <= 1'b0;
            pending_q <= 1'b0;
        end
        else
        begin
            busy_q <= busy_i;
            // clear wins over a fall in the same cycle
            if (clr_i)
                pending_q <= 1'b0;
            else if (busy_q && !busy_i)
                pending_q <= 1'b1;
        end
    end

    assign pending_o = pending_q;
    assign irq_o     = pending_q & en_i;

endmodule

`default_nettype wire

/* source/mem_word_port.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_word_port
#(
    parameter type cmd_t = logic [31:0],
    parameter type rsp_t = logic [31:0]
)
(
    input  logic ACLK,
    input  logic ARESETn,

    // sequencer side
    input  logic go_i,
    input  cmd_t cmd_i,
    output logic done_o,
    output rsp_t rsp_o,

    // memory side, four-phase req/ack
    output logic req_o,
    output cmd_t cmd_o,
    input  logic ack_i,
    input  rsp_t rsp_i
);
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_ACK_LOW
    } state_e;

    state_e state_q;
    logic   done_q;
    cmd_t   cmd_q;
    rsp_t   rsp_q;

    assign req_o  = (state_q == REQ);
    assign cmd_o  = cmd_q;
    assign rsp_o  = rsp_q;
    assign done_o = done_q;

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            state_q <= IDLE;
            done_q  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            case (state_q)
                IDLE:
                    if (go_i)
                        state_q <= REQ;
                REQ:
                    if (ack_i)
                        state_q <= WAIT_ACK_LOW;
                WAIT_ACK_LOW:
                    if (!ack_i)
                    begin
                        done_q  <= 1'b1;
                        state_q <= IDLE;
                    end
                default:
                    state_q <= IDLE;
            endcase
        end
    end

    // command held stable for the whole req phase
    always_ff @(posedge ACLK)
    begin
        if (go_i && (state_q == IDLE))
            cmd_q <= cmd_i;
        if (ack_i && (state_q == REQ))
            rsp_q <= rsp_i;
    end

endmodule

`default_nettype wire

/* sweep/field_addr_gen.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fdtd_params.svh"

module field_addr_gen
(
    input  logic                    ACLK,
    input  logic                    ARESETn,

    input  logic                    load_i,
    input  fdtd_pkg::sweep_cfg_t    cfg_i,

    input  fdtd_pkg::field_e        field_i,
    input  logic [`FDTD_SIZE_W-1:0] word_idx_i,
    output logic [`FDTD_ADDR_W-1:0] addr_o
);
    import fdtd_pkg::*;

    localparam int ADDR_W = `FDTD_ADDR_W;
    localparam int SIZE_W = `FDTD_SIZE_W;

    logic [ADDR_W-1:0] hy_base_q;
    logic [ADDR_W-1:0] ez_base_q;
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] byte_off;

    ////////////////////////////////////////////////////////////////////////////
    // array bases

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            hy_base_q <= '0;
            ez_base_q <= '0;
        end
        else if (load_i)
        begin
            hy_base_q <= cfg_i.hy_base;
            ez_base_q <= cfg_i.ez_base;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // word index to byte address

    assign base     = (field_i == FIELD_EZ) ? ez_base_q : hy_base_q;

    // 4 bytes per word
    assign byte_off = {{(ADDR_W-SIZE_W-2){1'b0}}, word_idx_i, 2'b00};

    assign addr_o   = base + byte_off;

endmodule

`default_nettype wire

/* sweep/sweep_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fdtd_params.svh"

module sweep_fsm
(
    input  logic                    ACLK,
    input  logic                    ARESETn,

    input  logic                    start_i,
    input  fdtd_pkg::sweep_cfg_t    cfg_i,

    input  logic [`FDTD_ADDR_W-1:0] addr_i,
    output fdtd_pkg::field_e        field_o,
    output logic [`FDTD_SIZE_W-1:0] word_idx_o,

    output logic                    rd_go_o,
    output fdtd_pkg::mem_rd_cmd_t   rd_cmd_o,
    input  logic                    rd_done_i,
    input  fdtd_pkg::mem_rd_rsp_t   rd_rsp_i,

    output logic                    wr_go_o,
    output fdtd_pkg::mem_wr_cmd_t   wr_cmd_o,
    input  logic                    wr_done_i,

    output fdtd_pkg::field_beat_t   rd_beat_o,
    output logic                    calc_start_o,
    input  fdtd_pkg::upd_beat_t     upd_beat_i,
    output logic                    upd_ready_o,
    output logic                    busy_o
);
    import fdtd_pkg::*;

    localparam int SIZE_W = `FDTD_SIZE_W;
    localparam int IDX_W  = `FDTD_BLK_IDX_W;
    localparam int LEN_W  = `FDTD_BLK_IDX_W + 1;

    typedef enum logic [2:0] {
        IDLE,
        READ_HY,
        READ_EZ,
        CALC_START,
        WRITE,
        DONE
    } state_e;

    state_e             state_q;
    logic               busy_q;
    field_e             field_q;
    logic [SIZE_W-1:0]  remain_q;
    logic [SIZE_W-1:0]  blk_base_q;
    logic [IDX_W-1:0]   idx_q;
    logic               rd_pend_q;
    logic               wr_pend_q;
    logic               calc_start_q;
    field_beat_t        rd_beat_q;

    logic [LEN_W-1:0]   blk_len;
    logic [LEN_W-1:0]   blk_len_m1;
    logic [SIZE_W-1:0]  blk_len_ext;
    logic               last_in_blk;
    logic               last_blk;

    ////////////////////////////////////////////////////////////////////////////
    // block geometry

    // a short last block covers whatever is left
    assign blk_len     = (remain_q >= SIZE_W'(`FDTD_BLOCK_WORDS)) ?
                         LEN_W'(`FDTD_BLOCK_WORDS) : remain_q[LEN_W-1:0];
    assign blk_len_m1  = blk_len - 1'b1;
    assign blk_len_ext = {{(SIZE_W-LEN_W){1'b0}}, blk_len};
    assign last_in_blk = (idx_q == blk_len_m1[IDX_W-1:0]);
    assign last_blk    = (remain_q == blk_len_ext);

    assign word_idx_o  = blk_base_q + {{(SIZE_W-IDX_W){1'b0}}, idx_q};

    always_comb
    begin
        case (state_q)
            READ_HY: field_o = FIELD_HY;
            READ_EZ: field_o = FIELD_EZ;
            default: field_o = field_q;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // memory and calc handshakes

    assign rd_go_o       = ((state_q == READ_HY) || (state_q == READ_EZ)) && !rd_pend_q;
    assign rd_cmd_o.addr = addr_i;

    assign upd_ready_o   = (state_q == WRITE) && !wr_pend_q;
    assign wr_go_o       = upd_ready_o && upd_beat_i.valid;
    assign wr_cmd_o.addr = addr_i;
    assign wr_cmd_o.data = upd_beat_i.data;

    assign rd_beat_o     = rd_beat_q;
    assign calc_start_o  = calc_start_q;
    assign busy_o        = busy_q;

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            state_q      <= IDLE;
            busy_q       <= 1'b0;
            field_q      <= FIELD_HY;
            remain_q     <= '0;
            blk_base_q   <= '0;
            idx_q        <= '0;
            rd_pend_q    <= 1'b0;
            wr_pend_q    <= 1'b0;
            calc_start_q <= 1'b0;
        end
        else
        begin
            calc_start_q <= (state_q == CALC_START);
            case (state_q)
                IDLE, DONE:
                begin
                    if (start_i && !busy_q)
                    begin
                        busy_q     <= 1'b1;
                        field_q    <= cfg_i.field;
                        remain_q   <= cfg_i.size;
                        blk_base_q <= '0;
                        idx_q      <= '0;
                        state_q    <= (cfg_i.size == '0) ? DONE : READ_HY;
                    end
                    else
                    begin
                        busy_q  <= 1'b0;
                        state_q <= IDLE;
                    end
                end

                READ_HY, READ_EZ:
                begin
                    if (rd_go_o)
                        rd_pend_q <= 1'b1;
                    if (rd_done_i)
                    begin
                        rd_pend_q <= 1'b0;
                        if (last_in_blk)
                        begin
                            idx_q   <= '0;
                            state_q <= (state_q == READ_HY) ? READ_EZ : CALC_START;
                        end
                        else
                            idx_q <= idx_q + 1'b1;
                    end
                end

                CALC_START:
                    state_q <= WRITE;

                WRITE:
                begin
                    if (wr_go_o)
                        wr_pend_q <= 1'b1;
                    if (wr_done_i)
                    begin
                        wr_pend_q <= 1'b0;
                        if (!last_in_blk)
                            idx_q <= idx_q + 1'b1;
                        else if (last_blk)
                        begin
                            idx_q   <= '0;
                            busy_q  <= 1'b0;
                            state_q <= DONE;
                        end
                        else
                        begin
                            // next block starts right after this one
                            idx_q      <= '0;
                            remain_q   <= remain_q - blk_len_ext;
                            blk_base_q <= blk_base_q + blk_len_ext;
                            state_q    <= READ_HY;
                        end
                    end
                end

                default:
                    state_q <= IDLE;
            endcase
        end
    end

    // forwarded word, one cycle after its read completes
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            rd_beat_q <= '0;
        else
        begin
            rd_beat_q.valid <= rd_done_i;
            if (rd_done_i)
            begin
                rd_beat_q.field <= field_o;
                rd_beat_q.idx   <= idx_q;
                rd_beat_q.data  <= rd_rsp_i.data;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/tb_fdtd_mem_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_fdtd_mem_ctrl;
    import fdtd_pkg::*;

    localparam logic [31:0] HY_BASE = 32'h100;
    localparam logic [31:0] EZ_BASE = 32'h300;
    localparam int          WORDS   = 21 + 13 + 11;

    logic ACLK = 1'b0;
    logic ARESETn;
    logic start, busy, irq_en, irq_clr, irq_pending, irq, calc_start, upd_ready;
    logic rd_req, rd_ack, wr_req, wr_ack, rd_req_q;
    sweep_cfg_t  cfg;
    field_beat_t rd_beat;
    upd_beat_t   upd_beat;
    mem_rd_cmd_t rd_cmd;
    mem_rd_rsp_t rd_rsp;
    mem_wr_cmd_t wr_cmd;
    logic [15:0] proto_err;
    logic [31:0] init_img [0:255];
    logic [31:0] exp_addr [$];
    logic [35:0] exp_beat [$];
    logic [31:0] seed = 32'h5129_0aa9;
    int          err_cnt = 0;

    always #10 ACLK = ~ACLK;

    fdtd_mem_ctrl u_dut
    (
        .ACLK (ACLK), .ARESETn (ARESETn), .start_i (start), .cfg_i (cfg), .busy_o (busy),
        .irq_en_i (irq_en), .irq_clr_i (irq_clr), .irq_pending_o (irq_pending),
        .irq_o (irq), .rd_beat_o (rd_beat), .calc_start_o (calc_start),
        .upd_beat_i (upd_beat), .upd_ready_o (upd_ready), .mem_rd_req_o (rd_req),
        .mem_rd_cmd_o (rd_cmd), .mem_rd_ack_i (rd_ack), .mem_rd_rsp_i (rd_rsp),
        .mem_wr_req_o (wr_req), .mem_wr_cmd_o (wr_cmd), .mem_wr_ack_i (wr_ack)
    );

    tb_mem_model u_mem
    (
        .ACLK (ACLK), .rd_req_i (rd_req), .rd_cmd_i (rd_cmd), .rd_ack_o (rd_ack),
        .rd_rsp_o (rd_rsp), .wr_req_i (wr_req), .wr_cmd_i (wr_cmd), .wr_ack_o (wr_ack),
        .rd_beat_i (rd_beat), .calc_start_i (calc_start), .busy_i (busy),
        .field_i (cfg.field), .upd_ready_i (upd_ready), .upd_beat_o (upd_beat),
        .proto_err_o (proto_err)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // updated target word from the image saved at sweep start
    function automatic logic [31:0] ref_word(input int tgt_w, input int oth_w, input int i);
        logic [31:0] prev;
        prev = (i == 0) ? 32'h0 : init_img[oth_w+i-1];
        return init_img[tgt_w+i] + init_img[oth_w+i] - prev;
    endfunction

    task automatic report(input string what, input logic [35:0] got, input logic [35:0] exp);
        $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
        err_cnt++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // read order and forwarded beats

    always @(negedge ACLK)
    begin
        if (rd_req && !rd_req_q)
        begin
            if (exp_addr.size() == 0)
                report("unexpected read addr", rd_cmd.addr, 32'h0);
            else if (rd_cmd.addr != exp_addr[0])
                report("read addr", rd_cmd.addr, exp_addr[0]);
            if (exp_addr.size() != 0)
                void'(exp_addr.pop_front());
        end
        rd_req_q <= rd_req;
        if (rd_beat.valid)
        begin
            if (exp_beat.size() == 0)
                report("unexpected beat", rd_beat.data, 32'h0);
            else if (rd_beat[35:0] != exp_beat[0])
                report("beat", rd_beat[35:0], exp_beat[0]);
            if (exp_beat.size() != 0)
                void'(exp_beat.pop_front());
        end
    end

    task automatic run_sweep(input field_e fld, input int size, input bit extra_start);
        logic [31:0] exp_img [0:255];
        int tgt_w, oth_w, n;
        bit was_pending;
        for (int a = 0; a < 256; a++)
            init_img[a] = u_mem.mem[a];
        exp_img = init_img;
        tgt_w = (fld == FIELD_HY) ? HY_BASE / 4 : EZ_BASE / 4;
        oth_w = (fld == FIELD_HY) ? EZ_BASE / 4 : HY_BASE / 4;
        for (int i = 0; i < size; i++)
            exp_img[tgt_w+i] = ref_word(tgt_w, oth_w, i);
        for (int b = 0; b < size; b += 8)
        begin
            n = (size - b < 8) ? size - b : 8;
            for (int f = 0; f < 2; f++)
                for (int k = 0; k < n; k++)
                begin
                    exp_addr.push_back((f == 0 ? HY_BASE : EZ_BASE) + 4 * (b + k));
                    exp_beat.push_back({f[0], k[2:0],
                        init_img[(f == 0 ? HY_BASE : EZ_BASE) / 4 + b + k]});
                end
        end
        was_pending = irq_pending;
        @(posedge ACLK);
        #2;
        start = 1'b1;
        cfg   = '{hy_base: HY_BASE, ez_base: EZ_BASE, size: size[15:0], field: fld};
        @(posedge ACLK);
        #2;
        start = 1'b0;
        if (busy !== 1'b1)
            report("busy after start", busy, 1);
        if (extra_start)
        begin
            repeat (5)
                @(posedge ACLK);
            #2;
            start = 1'b1;
            cfg   = '{hy_base: EZ_BASE, ez_base: HY_BASE, size: 16'd5, field: FIELD_EZ};
            @(posedge ACLK);
            #2;
            start = 1'b0;
            cfg   = '{hy_base: HY_BASE, ez_base: EZ_BASE, size: size[15:0], field: fld};
        end
        @(negedge ACLK);
        while (busy)
            @(negedge ACLK);
        if (irq_pending !== was_pending)
            report("pending before rise", irq_pending, was_pending);
        @(negedge ACLK);
        if (irq_pending !== 1'b1 || irq !== irq_en)
            report("pending/irq after busy fall", {irq_pending, irq}, {1'b1, irq_en});
        for (int a = 0; a < 256; a++)
            if (u_mem.mem[a] !== exp_img[a])
                report($sformatf("mem word %0d", a), u_mem.mem[a], exp_img[a]);
        if (exp_addr.size() != 0 || exp_beat.size() != 0)
        begin
            $display("%0t ns: reads missing at end of sweep", $time);
            err_cnt++;
        end
    endtask

    initial
    begin
        #((WORDS * 200 + 500) * 20);
        $display("watchdog expired, the DUT did not finish its sweeps");
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        ARESETn  = 1'b0;
        start    = 1'b0;
        cfg      = '0;
        irq_en   = 1'b1;
        irq_clr  = 1'b0;
        rd_req_q = 1'b0;
        for (int a = 0; a < 256; a++)
        begin
            seed        = lcg_next(seed);
            u_mem.mem[a] = seed ^ (a * 32'h0101_0101);
        end
        repeat (5)
            @(posedge ACLK);
        #2;
        ARESETn = 1'b1;
        run_sweep(FIELD_HY, 21, 1'b0);
        @(posedge ACLK);
        #2;
        irq_en = 1'b0;
        @(negedge ACLK);
        if (irq !== 1'b0)
            report("irq with enable low", irq, 0);
        // pending stays set through the next sweep
        run_sweep(FIELD_EZ, 13, 1'b0);
        @(posedge ACLK);
        #2;
        irq_clr = 1'b1;
        @(posedge ACLK);
        #2;
        irq_clr = 1'b0;
        irq_en  = 1'b1;
        if (irq_pending !== 1'b0)
            report("pending after clear", irq_pending, 0);
        run_sweep(FIELD_HY, 11, 1'b1);
        $display("value errors: %0d, protocol errors: %0d", err_cnt, proto_err);
        if (err_cnt == 0 && proto_err == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/tb_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model
#(
    parameter logic [31:0] SEED = 32'h5129_0aa9
)
(
    input  logic                  ACLK,
    input  logic                  rd_req_i,
    input  fdtd_pkg::mem_rd_cmd_t rd_cmd_i,
    output logic                  rd_ack_o,
    output fdtd_pkg::mem_rd_rsp_t rd_rsp_o,
    input  logic                  wr_req_i,
    input  fdtd_pkg::mem_wr_cmd_t wr_cmd_i,
    output logic                  wr_ack_o,
    input  fdtd_pkg::field_beat_t rd_beat_i,
    input  logic                  calc_start_i,
    input  logic                  busy_i,
    input  fdtd_pkg::field_e      field_i,
    input  logic                  upd_ready_i,
    output fdtd_pkg::upd_beat_t   upd_beat_o,
    output logic [15:0]           proto_err_o
);
    import fdtd_pkg::*;

    logic [31:0] mem [0:255];
    logic [31:0] rnd = SEED;
    logic [31:0] hy_buf [0:7];
    logic [31:0] ez_buf [0:7];
    logic [31:0] carry;
    logic        busy_q;
    logic        rd_req_q;
    logic        wr_req_q;
    int          rd_wait;
    int          wr_wait;
    int          blk_n;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // read and write slaves, ack rises and falls after 0 to 3 cycles

    initial
    begin
        rd_ack_o    = 1'b0;
        rd_rsp_o    = '0;
        wr_ack_o    = 1'b0;
        proto_err_o = '0;
        rd_req_q    = 1'b0;
        wr_req_q    = 1'b0;
        rd_wait     = -1;
        wr_wait     = -1;
        forever
        begin
            @(posedge ACLK);
            #2;
            // req may only rise once ack is low
            if (rd_req_i && !rd_req_q && rd_ack_o)
            begin
                $display("%0t ns: read req rose while ack was still high", $time);
                proto_err_o = proto_err_o + 1'b1;
            end
            if (wr_req_i && !wr_req_q && wr_ack_o)
            begin
                $display("%0t ns: write req rose while ack was still high", $time);
                proto_err_o = proto_err_o + 1'b1;
            end
            rd_req_q = rd_req_i;
            wr_req_q = wr_req_i;
            if (rd_ack_o)
            begin
                if (!rd_req_i)
                begin
                    // ack may linger after req drops
                    if (rd_wait < 0)
                    begin
                        rnd     = lcg_next(rnd);
                        rd_wait = rnd[23:22];
                    end
                    if (rd_wait == 0)
                    begin
                        rd_ack_o = 1'b0;
                        rd_wait  = -1;
                    end
                    else
                        rd_wait = rd_wait - 1;
                end
            end
            else if (rd_req_i)
            begin
                if (rd_wait < 0)
                begin
                    rnd     = lcg_next(rnd);
                    rd_wait = rnd[17:16];
                end
                if (rd_wait == 0)
                begin
                    rd_ack_o      = 1'b1;
                    rd_rsp_o.data = mem[rd_cmd_i.addr[9:2]];
                    rd_wait       = -1;
                end
                else
                    rd_wait = rd_wait - 1;
            end
            if (wr_ack_o)
            begin
                if (!wr_req_i)
                begin
                    if (wr_wait < 0)
                    begin
                        rnd     = lcg_next(rnd);
                        wr_wait = rnd[25:24];
                    end
                    if (wr_wait == 0)
                    begin
                        wr_ack_o = 1'b0;
                        wr_wait  = -1;
                    end
                    else
                        wr_wait = wr_wait - 1;
                end
            end
            else if (wr_req_i)
            begin
                if (wr_wait < 0)
                begin
                    rnd     = lcg_next(rnd);
                    wr_wait = rnd[19:18];
                end
                if (wr_wait == 0)
                begin
                    wr_ack_o                  = 1'b1;
                    mem[wr_cmd_i.addr[9:2]]   = wr_cmd_i.data;
                    wr_wait                   = -1;
                end
                else
                    wr_wait = wr_wait - 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // calc unit

    task automatic send_updates();
        logic [31:0] tgt;
        logic [31:0] oth;
        logic [31:0] prev;
        for (int k = 0; k < blk_n; k++)
        begin
            tgt  = (field_i == FIELD_HY) ? hy_buf[k] : ez_buf[k];
            oth  = (field_i == FIELD_HY) ? ez_buf[k] : hy_buf[k];
            prev = (k == 0) ? carry : ((field_i == FIELD_HY) ? ez_buf[k-1] : hy_buf[k-1]);
            rnd  = lcg_next(rnd);
            repeat (rnd[21:20] % 3)
                @(posedge ACLK);
            @(posedge ACLK);
            #2;
            upd_beat_o.valid = 1'b1;
            upd_beat_o.data  = tgt + oth - prev;
            // held until the DUT is ready
            @(negedge ACLK);
            while (!upd_ready_i)
                @(negedge ACLK);
            @(posedge ACLK);
            #2;
            upd_beat_o.valid = 1'b0;
        end
        carry = (field_i == FIELD_HY) ? ez_buf[blk_n-1] : hy_buf[blk_n-1];
    endtask

    initial
    begin
        upd_beat_o = '0;
        carry      = '0;
        busy_q     = 1'b0;
        blk_n      = 0;
        forever
        begin
            @(negedge ACLK);
            if (busy_i && !busy_q)
                carry = '0;
            busy_q = busy_i;
            if (rd_beat_i.valid)
            begin
                if (rd_beat_i.field == FIELD_HY)
                begin
                    hy_buf[rd_beat_i.idx] = rd_beat_i.data;
                    blk_n                 = rd_beat_i.idx + 1;
                end
                else
                    ez_buf[rd_beat_i.idx] = rd_beat_i.data;
            end
            if (calc_start_i)
                send_updates();
        end
    end

endmodule

`default_nettype wire
